//--- burstCounter.sv
// Nibble-loaded burst count; decrements per burst gatedEn pulse and stops at zero
// A load in the same cycle as a decrement wins
`default_nettype none

module burstCounter (
  input  logic                       MAIN_SOURCE,
  input  logic                       CLK,
  funcBus.consumer                   fb,
  input  logic                       burstRun,
  input  logic                       gatedEn,
  output logic [clkPkg::BURST_W-1:0] count
);
  import clkPkg::*;

  logic countDown;

  // Only burst pulses consume the count
  assign countDown = burstRun & gatedEn & (count != '0);

  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      count <= '0;
    end else if (fb.ldBurstLsb) begin
      // Low nibble
      count[LOAD_W-1:0] <= fb.loadData;
    end else if (fb.ldBurstMsb) begin
      // High nibble
      count[BURST_W-1:LOAD_W] <= fb.loadData;
    end else if (countDown) begin
      count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- clkPkg.sv
// Shared widths, function codes and readback selects for the clock controller
// Load and readback select values share the DS_W wide diagnostic select field
`default_nettype none

package clkPkg;

  // Diagnostic select field
  localparam int DS_W = 3;
  // Load data nibble, EBUS data bits 32 to 35 with bit 35 as LSB
  localparam int LOAD_W = 4;
  // Readback bus
  localparam int READ_W = 6;
  localparam int BURST_W = 8;
  // Rate select and source select share this width
  localparam int RATE_W = 2;
  // CRAM time field
  localparam int TIME_W = 2;

  // Divider counter covers the slowest rate, 2**(2**RATE_W - 1) cycles
  localparam int DIV_W = 2 ** RATE_W - 1;

  // EBUS reset stretch
  localparam int EBUS_RESET_CYCLES = 16;
  localparam int EBUS_RESET_W = $clog2(EBUS_RESET_CYCLES + 1);

  // Control function codes, valid with the control strobe
  // Codes 0, 3 and 4 decode to nothing
  typedef enum logic [DS_W-1:0] {
    FN_START       = 3'd1,
    FN_SINGLE_STEP = 3'd2,
    FN_BURST       = 3'd5,
    FN_CLR_RESET   = 3'd6,
    FN_SET_RESET   = 3'd7
  } funcCode;

  // Load function numbers, valid with the load strobe
  localparam logic [DS_W-1:0] LD_BURST_LSB   = 3'd2;
  localparam logic [DS_W-1:0] LD_BURST_MSB   = 3'd3;
  localparam logic [DS_W-1:0] LD_RATE_SOURCE = 3'd4;
  localparam logic [DS_W-1:0] LD_EBOX_DIS    = 3'd5;

  // Readback selects, 4 to 7 read as zero
  localparam logic [DS_W-1:0] RD_BURST_MSB   = 3'd0;
  localparam logic [DS_W-1:0] RD_BURST_LSB   = 3'd1;
  localparam logic [DS_W-1:0] RD_RUN_STATUS  = 3'd2;
  localparam logic [DS_W-1:0] RD_EBOX_STATUS = 3'd3;

endpackage

`default_nettype wire

//--- clockControl.sv
// Diagnostic clock controller, single MAIN_SOURCE domain with async reset CLK
// No three-state drive; readData is zero while readDriving is low
`default_nettype none

module clockControl (
  input  logic                      MAIN_SOURCE,
  input  logic                      CLK,
  input  logic                      diagCtlFunc,
  input  logic                      diagLdFunc,
  input  logic                      diagReadFunc,
  input  logic [clkPkg::DS_W-1:0]   ds,
  input  logic [clkPkg::LOAD_W-1:0] data,
  input  logic [clkPkg::TIME_W-1:0] timeField,
  input  logic                      mboxWait,
  output logic                      gatedEn,
  output logic                      eboxClk,
  output logic                      clkCrm,
  output logic                      clkEdp,
  output logic                      clkCtl,
  output logic                      mrReset,
  output logic                      ebusReset,
  output logic [clkPkg::READ_W-1:0] readData,
  output logic                      readDriving
);
  import clkPkg::*;

  logic [BURST_W-1:0] count;
  logic               burstZero;
  logic               go;
  logic               burstRun;
  logic [RATE_W-1:0]  rateSel;
  logic [RATE_W-1:0]  sourceSel;
  logic [2:0]         eboxDis;

  // Decoded function pulses
  funcBus fb ();

  assign burstZero = (count == '0);

  diagFunctionDecoder decoder_i (
    .MAIN_SOURCE (MAIN_SOURCE),
    .CLK         (CLK),
    .diagCtlFunc (diagCtlFunc),
    .diagLdFunc  (diagLdFunc),
    .ds          (ds),
    .data        (data),
    .fb          (fb.decoder)
  );

  resetControl reset_i (
    .MAIN_SOURCE (MAIN_SOURCE),
    .CLK         (CLK),
    .fb          (fb.consumer),
    .mrReset     (mrReset),
    .ebusReset   (ebusReset)
  );

  burstCounter burst_i (
    .MAIN_SOURCE (MAIN_SOURCE),
    .CLK         (CLK),
    .fb          (fb.consumer),
    .burstRun    (burstRun),
    .gatedEn     (gatedEn),
    .count       (count)
  );

  clockGate gate_i (
    .MAIN_SOURCE (MAIN_SOURCE),
    .CLK         (CLK),
    .fb          (fb.consumer),
    .burstZero   (burstZero),
    .gatedEn     (gatedEn),
    .go          (go),
    .burstRun    (burstRun),
    .rateSel     (rateSel),
    .sourceSel   (sourceSel)
  );

  eboxSync sync_i (
    .MAIN_SOURCE (MAIN_SOURCE),
    .CLK         (CLK),
    .fb          (fb.consumer),
    .gatedEn     (gatedEn),
    .mrReset     (mrReset),
    .timeField   (timeField),
    .mboxWait    (mboxWait),
    .eboxClk     (eboxClk),
    .clkCrm      (clkCrm),
    .clkEdp      (clkEdp),
    .clkCtl      (clkCtl),
    .eboxDis     (eboxDis)
  );

  diagReadback readback_i (
    .diagReadFunc (diagReadFunc),
    .ds           (ds),
    .count        (count),
    .go           (go),
    .burstRun     (burstRun),
    .mrReset      (mrReset),
    .ebusReset    (ebusReset),
    .rateSel      (rateSel),
    .sourceSel    (sourceSel),
    .eboxDis      (eboxDis),
    .eboxClk      (eboxClk),
    .readData     (readData),
    .readDriving  (readDriving)
  );

endmodule

`default_nettype wire

//--- clockControl_properties.sv
// Concurrent checks bound into clockControl, sampled on MAIN_SOURCE
// All checks are idle while CLK holds reset
`default_nettype none

module clockControl_properties (
  input logic                      MAIN_SOURCE,
  input logic                      CLK,
  input logic                      gatedEn,
  input logic                      eboxClk,
  input logic                      clkCrm,
  input logic                      clkEdp,
  input logic                      clkCtl,
  input logic                      go,
  input logic                      burstRun,
  input logic                      singleStep,
  input logic                      readDriving,
  input logic [clkPkg::READ_W-1:0] readData
);

  // Failures so far, watched by the testbench
  integer failCount;

  initial begin
    failCount = 0;
  end

  // Idle bus reads zero
  readIdleZero: assert property (@(posedge MAIN_SOURCE) disable iff (CLK)
    !readDriving |-> (readData == '0))
    else begin
      $error("readData nonzero while readDriving is low");
      failCount = failCount + 1;
    end

  // Section enables only with eboxClk
  sectionEnables: assert property (@(posedge MAIN_SOURCE) disable iff (CLK)
    (clkCrm || clkEdp || clkCtl) |-> eboxClk)
    else begin
      $error("section clock enable without eboxClk");
      failCount = failCount + 1;
    end

  eboxNeedsGated: assert property (@(posedge MAIN_SOURCE) disable iff (CLK)
    eboxClk |-> gatedEn)
    else begin
      $error("eboxClk without gatedEn");
      failCount = failCount + 1;
    end

  // Stopped clock, except the single step enable
  stoppedQuiet: assert property (@(posedge MAIN_SOURCE) disable iff (CLK)
    (!go && !burstRun && !$past(singleStep)) |-> !gatedEn)
    else begin
      $error("gatedEn while stopped and not single stepping");
      failCount = failCount + 1;
    end

endmodule

bind clockControl clockControl_properties props_i (
  .MAIN_SOURCE (MAIN_SOURCE),
  .CLK         (CLK),
  .gatedEn     (gatedEn),
  .eboxClk     (eboxClk),
  .clkCrm      (clkCrm),
  .clkEdp      (clkEdp),
  .clkCtl      (clkCtl),
  .go          (go),
  .burstRun    (burstRun),
  .singleStep  (fb.singleStep),
  .readDriving (readDriving),
  .readData    (readData)
);

`default_nettype wire

//--- clockControl_tb.sv
// Testbench for clockControl; checks run on the falling edge of MAIN_SOURCE
// Burst counts, rates, time fields and disables come from $random with a fixed seed
`default_nettype none

module clockControl_tb;
  import clkPkg::*;

  logic              MAIN_SOURCE;
  logic              CLK;
  logic              diagCtlFunc;
  logic              diagLdFunc;
  logic              diagReadFunc;
  logic [DS_W-1:0]   ds;
  logic [LOAD_W-1:0] data;
  logic [TIME_W-1:0] timeField;
  logic              mboxWait;
  logic              gatedEn;
  logic              eboxClk;
  logic              clkCrm;
  logic              clkEdp;
  logic              clkCtl;
  logic              mrReset;
  logic              ebusReset;
  logic [READ_W-1:0] readData;
  logic              readDriving;

  // Checker state
  integer seed;
  integer cycle;
  integer gatedPulses;
  integer eboxPulses;
  integer crmPulses;
  integer edpPulses;
  integer ctlPulses;
  integer lastGated;
  integer expSpacing;
  integer sinceEbox;
  integer expPeriod;
  integer ebusRun;
  integer ebusLastRun;
  integer stepMark;
  logic   spacingOn;
  logic   eboxOn;
  logic   eboxSynced;
  logic [2:0] expDis;

  // Stimulus values
  integer             n;
  integer             i;
  logic [READ_W-1:0]  rdVal;
  logic [BURST_W-1:0] burstN;
  logic [RATE_W-1:0]  rate;
  logic [RATE_W-1:0]  src;
  logic [TIME_W-1:0]  tfVal;
  logic [2:0]         dis;

  clockControl dut_i (.*);

  initial begin
    MAIN_SOURCE = 1'b0;
  end

  always #50 MAIN_SOURCE = ~MAIN_SOURCE;

  task automatic stopRun(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkValue(input string name, input integer got, input integer exp);
    assert (got == exp) else begin
      stopRun($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Control function with the strobe held four cycles and dropped for two
  task automatic ctlFunc(input logic [DS_W-1:0] code);
    @(posedge MAIN_SOURCE);
    diagCtlFunc <= 1'b1;
    ds          <= code;
    // Function pulse ends on the third edge
    repeat (3) @(posedge MAIN_SOURCE);
    stepMark = gatedPulses;
    @(posedge MAIN_SOURCE);
    diagCtlFunc <= 1'b0;
    repeat (2) @(posedge MAIN_SOURCE);
  endtask

  task automatic ldFunc(input logic [DS_W-1:0] sel, input logic [LOAD_W-1:0] value);
    @(posedge MAIN_SOURCE);
    diagLdFunc <= 1'b1;
    ds         <= sel;
    data       <= value;
    repeat (3) @(posedge MAIN_SOURCE);
    // Disables take effect on this edge in crm edp ctl order
    if (sel == LD_EBOX_DIS) begin
      expDis = value[2:0];
    end
    @(posedge MAIN_SOURCE);
    diagLdFunc <= 1'b0;
    repeat (2) @(posedge MAIN_SOURCE);
  endtask

  // Read strobe held four cycles and sampled in its first cycle
  task automatic readField(input logic [DS_W-1:0] sel, output logic [READ_W-1:0] value);
    @(posedge MAIN_SOURCE);
    diagReadFunc <= 1'b1;
    ds           <= sel;
    @(negedge MAIN_SOURCE);
    value = readData;
    checkValue("readDriving", readDriving, 1);
    repeat (4) @(posedge MAIN_SOURCE);
    diagReadFunc <= 1'b0;
    @(negedge MAIN_SOURCE);
    checkValue("readDriving", readDriving, 0);
    repeat (2) @(posedge MAIN_SOURCE);
  endtask

  task automatic waitCount(input bit useEbox, input integer target, input integer limit);
    integer waited;
    waited = 0;
    while ((useEbox ? eboxPulses : gatedPulses) < target) begin
      @(posedge MAIN_SOURCE);
      waited = waited + 1;
      if (waited > limit) begin
        if (useEbox) begin
          stopRun("eboxClk stopped before the expected number of pulses");
        end else begin
          stopRun("gatedEn stopped before the expected number of pulses");
        end
      end
    end
  endtask

  task automatic waitEbusLow;
    integer waited;
    waited = 0;
    while (ebusReset) begin
      @(negedge MAIN_SOURCE);
      waited = waited + 1;
      if (waited > 2 * EBUS_RESET_CYCLES) begin
        stopRun("ebusReset stayed high far longer than the stretch length");
      end
    end
    // Lets the checker close the high run
    @(negedge MAIN_SOURCE);
  endtask

  // Pulse counting and per-cycle rules
  always @(negedge MAIN_SOURCE) begin
    cycle = cycle + 1;
    if (ebusReset) begin
      ebusRun = ebusRun + 1;
    end else if (ebusRun != 0) begin
      ebusLastRun = ebusRun;
      ebusRun     = 0;
    end
    if (gatedEn) begin
      gatedPulses = gatedPulses + 1;
      if (spacingOn && lastGated >= 0) begin
        checkValue("gatedEn spacing", cycle - lastGated, expSpacing);
      end
      lastGated = cycle;
      if (eboxOn) begin
        sinceEbox = sinceEbox + 1;
        if (eboxClk) begin
          // Every (timeField+1)-th gatedEn once in step
          if (eboxSynced) begin
            checkValue("eboxClk period", sinceEbox, expPeriod);
          end
          eboxSynced = 1'b1;
          sinceEbox  = 0;
        end
      end
    end
    if (eboxClk) begin
      eboxPulses = eboxPulses + 1;
      if (!gatedEn || mboxWait || mrReset) begin
        stopRun("eboxClk pulsed without gatedEn or during MBOX wait or machine reset");
      end
    end
    checkValue("clkCrm", clkCrm, eboxClk & ~expDis[2]);
    checkValue("clkEdp", clkEdp, eboxClk & ~expDis[1]);
    checkValue("clkCtl", clkCtl, eboxClk & ~expDis[0]);
    crmPulses = crmPulses + clkCrm;
    edpPulses = edpPulses + clkEdp;
    ctlPulses = ctlPulses + clkCtl;
    if (dut_i.props_i.failCount != 0) begin
      stopRun("a bound property assertion failed");
    end
  end

  initial begin : watchdog
    integer limit;
    // Reset, about 30 function sequences, longest burst, run windows, margin
    limit = 10 + 30 * 8 + 255 * 8 + 3 * 80 + 2 * 60 + 100 + 500;
    repeat (limit) @(posedge MAIN_SOURCE);
    stopRun("watchdog expired before the tests finished");
  end

  initial begin
    seed         = 51;
    CLK          = 1'b1;
    diagCtlFunc  = 1'b0;
    diagLdFunc   = 1'b0;
    diagReadFunc = 1'b0;
    ds           = '0;
    data         = '0;
    timeField    = '0;
    mboxWait     = 1'b0;
    cycle        = 0;
    gatedPulses  = 0;
    eboxPulses   = 0;
    crmPulses    = 0;
    edpPulses    = 0;
    ctlPulses    = 0;
    lastGated    = -1;
    expSpacing   = 1;
    sinceEbox    = 0;
    expPeriod    = 1;
    ebusRun      = 0;
    ebusLastRun  = 0;
    stepMark     = 0;
    spacingOn    = 1'b0;
    eboxOn       = 1'b0;
    eboxSynced   = 1'b0;
    expDis       = '0;
    repeat (10) @(posedge MAIN_SOURCE);
    CLK <= 1'b0;
    @(negedge MAIN_SOURCE);

    // Reset state then clear and set machine reset
    checkValue("mrReset", mrReset, 1);
    checkValue("ebusReset", ebusReset, 1);
    checkValue("gatedEn", gatedEn, 0);
    checkValue("eboxClk", eboxClk, 0);
    checkValue("readDriving", readDriving, 0);
    readField(RD_RUN_STATUS, rdVal);
    checkValue("readData", rdVal, 6'b100011);
    ctlFunc(FN_CLR_RESET);
    checkValue("mrReset", mrReset, 0);
    waitEbusLow();
    ctlFunc(FN_SET_RESET);
    checkValue("mrReset", mrReset, 1);
    waitEbusLow();
    checkValue("ebusReset cycles", ebusLastRun, EBUS_RESET_CYCLES);
    ctlFunc(FN_CLR_RESET);

    // Burst of N pulses at a random rate
    rate   = RATE_W'($random(seed));
    burstN = BURST_W'($random(seed));
    if (burstN == 0) begin
      burstN = 1;
    end
    ldFunc(LD_RATE_SOURCE, {2'b00, rate});
    ldFunc(LD_BURST_LSB, burstN[3:0]);
    ldFunc(LD_BURST_MSB, burstN[7:4]);
    readField(RD_BURST_LSB, rdVal);
    checkValue("readData", rdVal, burstN[3:0]);
    readField(RD_BURST_MSB, rdVal);
    checkValue("readData", rdVal, burstN[7:4]);
    n = gatedPulses;
    ctlFunc(FN_BURST);
    waitCount(1'b0, n + burstN, burstN * 8 + 20);
    repeat (40) @(posedge MAIN_SOURCE);
    checkValue("gatedEn burst pulses", gatedPulses - n, burstN);
    readField(RD_BURST_LSB, rdVal);
    checkValue("readData", rdVal, 0);
    readField(RD_BURST_MSB, rdVal);
    checkValue("readData", rdVal, 0);

    // Free run at random rates then one single step
    for (i = 0; i < 3; i = i + 1) begin
      rate      = RATE_W'($random(seed));
      src       = RATE_W'($random(seed));
      spacingOn = 1'b0;
      ldFunc(LD_RATE_SOURCE, {src, rate});
      ctlFunc(FN_START);
      expSpacing = 1 << rate;
      lastGated  = -1;
      spacingOn  = 1'b1;
      waitCount(1'b0, gatedPulses + 8, 8 * 8 + 8);
      spacingOn = 1'b0;
      readField(RD_RUN_STATUS, rdVal);
      checkValue("readData", rdVal, {2'b00, src, 2'b00});
    end
    ctlFunc(FN_SINGLE_STEP);
    repeat (20) @(posedge MAIN_SOURCE);
    checkValue("gatedEn after single step", gatedPulses - stepMark, 1);

    // Phase sync against a random time field then MBOX wait
    rate = RATE_W'($random(seed));
    ldFunc(LD_RATE_SOURCE, {2'b00, rate});
    ctlFunc(FN_START);
    for (i = 0; i < 2; i = i + 1) begin
      tfVal  = TIME_W'($random(seed));
      eboxOn = 1'b0;
      @(posedge MAIN_SOURCE);
      timeField <= tfVal;
      @(posedge MAIN_SOURCE);
      expPeriod  = tfVal + 1;
      eboxSynced = 1'b0;
      sinceEbox  = 0;
      eboxOn     = 1'b1;
      waitCount(1'b1, eboxPulses + 4, 5 * 4 * 8 + 10);
      eboxOn = 1'b0;
      @(posedge MAIN_SOURCE);
      mboxWait <= 1'b1;
      n = eboxPulses;
      repeat (20) @(posedge MAIN_SOURCE);
      checkValue("eboxClk pulses during MBOX wait", eboxPulses - n, 0);
      mboxWait <= 1'b0;
    end

    // Random disables on the section enables
    dis = 3'($random(seed));
    ldFunc(LD_EBOX_DIS, {1'b0, dis});
    crmPulses = 0;
    edpPulses = 0;
    ctlPulses = 0;
    n         = eboxPulses;
    waitCount(1'b1, eboxPulses + 6, 6 * 4 * 8 + 10);
    checkValue("clkCrm pulses", crmPulses, dis[2] ? 0 : eboxPulses - n);
    checkValue("clkEdp pulses", edpPulses, dis[1] ? 0 : eboxPulses - n);
    checkValue("clkCtl pulses", ctlPulses, dis[0] ? 0 : eboxPulses - n);
    // Stop the clocks so eboxClk reads low
    ctlFunc(FN_SINGLE_STEP);
    repeat (4) @(posedge MAIN_SOURCE);
    readField(RD_EBOX_STATUS, rdVal);
    checkValue("readData", rdVal, {rate, dis, 1'b0});

    if (dut_i.props_i.failCount == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stopRun("a bound property assertion failed");
    end
  end

endmodule

`default_nettype wire

//--- clockGate.sv
// Rate divider is free running, so the first tick after START falls anywhere in the period
// sourceSel is stored for readback only; there is a single clock
`default_nettype none

module clockGate (
  input  logic                      MAIN_SOURCE,
  input  logic                      CLK,
  funcBus.consumer                  fb,
  input  logic                      burstZero,
  output logic                      gatedEn,
  output logic                      go,
  output logic                      burstRun,
  output logic [clkPkg::RATE_W-1:0] rateSel,
  output logic [clkPkg::RATE_W-1:0] sourceSel
);
  import clkPkg::*;

  logic [DIV_W-1:0] divCnt;
  logic [DIV_W-1:0] rateMask;
  logic             rateTick;
  logic             stepPend;

  // Rate and source select, data bits 32-33 source and 34-35 rate
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      rateSel   <= '0;
      sourceSel <= '0;
    end else if (fb.ldRateSource) begin
      sourceSel <= fb.loadData[LOAD_W-1:RATE_W];
      rateSel   <= fb.loadData[RATE_W-1:0];
    end
  end

  // Tick when the low rateSel bits of the divider are all zero
  assign rateMask = ~({DIV_W{1'b1}} << rateSel);
  assign rateTick = ((divCnt & rateMask) == '0);

  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

  // Run mode state
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      go       <= 1'b0;
      burstRun <= 1'b0;
      stepPend <= 1'b0;
    end else begin
      if (fb.start) begin
        go <= 1'b1;
      end else if (fb.singleStep || fb.burst) begin
        go <= 1'b0;
      end
      // Burst ends once the count has run out
      if (fb.burst) begin
        burstRun <= 1'b1;
      end else if (fb.start || fb.singleStep || burstZero) begin
        burstRun <= 1'b0;
      end
      // Single step gives one enable, rate ignored
      stepPend <= fb.singleStep;
    end
  end

  assign gatedEn = (rateTick & go) | (rateTick & burstRun & ~burstZero) | stepPend;

endmodule

`default_nettype wire

//--- diagFunctionDecoder.sv
// Strobes, ds and data must stay stable until funcGate, two cycles after the strobe rises
// Only one strobe is expected active at a time
`default_nettype none

module diagFunctionDecoder (
  input  logic                      MAIN_SOURCE,
  input  logic                      CLK,
  input  logic                      diagCtlFunc,
  input  logic                      diagLdFunc,
  input  logic [clkPkg::DS_W-1:0]   ds,
  input  logic [clkPkg::LOAD_W-1:0] data,
  funcBus.decoder                   fb
);
  import clkPkg::*;

  logic anyFunc;
  logic anyFuncQ;
  logic funcRise;
  logic syncA;
  logic funcGate;

  // Either strobe starts a function
  assign anyFunc  = diagCtlFunc | diagLdFunc;
  assign funcRise = anyFunc & ~anyFuncQ;

  // Edge detect then two-stage delay to funcGate
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      anyFuncQ <= 1'b0;
      syncA    <= 1'b0;
      funcGate <= 1'b0;
    end else begin
      anyFuncQ <= anyFunc;
      syncA    <= funcRise;
      funcGate <= syncA;
    end
  end

  // One-hot decode in the funcGate cycle
  always_comb begin
    fb.start        = 1'b0;
    fb.singleStep   = 1'b0;
    fb.burst        = 1'b0;
    fb.clrReset     = 1'b0;
    fb.setReset     = 1'b0;
    fb.ldBurstLsb   = 1'b0;
    fb.ldBurstMsb   = 1'b0;
    fb.ldRateSource = 1'b0;
    fb.ldEboxDis    = 1'b0;
    if (funcGate && diagCtlFunc) begin
      // EBOX_SS and COND_SS codes fall into default
      case (funcCode'(ds))
        FN_START:       fb.start      = 1'b1;
        FN_SINGLE_STEP: fb.singleStep = 1'b1;
        FN_BURST:       fb.burst      = 1'b1;
        FN_CLR_RESET:   fb.clrReset   = 1'b1;
        FN_SET_RESET:   fb.setReset   = 1'b1;
        default: ;
      endcase
    end else if (funcGate && diagLdFunc) begin
      case (ds)
        LD_BURST_LSB:   fb.ldBurstLsb   = 1'b1;
        LD_BURST_MSB:   fb.ldBurstMsb   = 1'b1;
        LD_RATE_SOURCE: fb.ldRateSource = 1'b1;
        LD_EBOX_DIS:    fb.ldEboxDis    = 1'b1;
        default: ;
      endcase
    end
  end

  // Data nibble passes straight through
  assign fb.loadData = data;

endmodule

`default_nettype wire

//--- diagReadback.sv
// Combinational readback; zeros on the bus when no read is active
`default_nettype none

module diagReadback (
  input  logic                       diagReadFunc,
  input  logic [clkPkg::DS_W-1:0]    ds,
  input  logic [clkPkg::BURST_W-1:0] count,
  input  logic                       go,
  input  logic                       burstRun,
  input  logic                       mrReset,
  input  logic                       ebusReset,
  input  logic [clkPkg::RATE_W-1:0]  rateSel,
  input  logic [clkPkg::RATE_W-1:0]  sourceSel,
  input  logic [2:0]                 eboxDis,
  input  logic                       eboxClk,
  output logic [clkPkg::READ_W-1:0]  readData,
  output logic                       readDriving
);
  import clkPkg::*;

  assign readDriving = diagReadFunc;

  always_comb begin
    readData = '0;
    if (diagReadFunc) begin
      case (ds)
        // Count nibbles, upper bits zero
        RD_BURST_MSB: readData = {{(READ_W - LOAD_W){1'b0}}, count[BURST_W-1:LOAD_W]};
        RD_BURST_LSB: readData = {{(READ_W - LOAD_W){1'b0}}, count[LOAD_W-1:0]};
        // Run bit reads inverted, as on the clock board
        RD_RUN_STATUS: begin
          readData = {~go, burstRun, sourceSel, mrReset, ebusReset};
        end
        // Rate, then crm edp ctl disables, then EBOX clock
        RD_EBOX_STATUS: begin
          readData = {rateSel, eboxDis[2], eboxDis[1], eboxDis[0], eboxClk};
        end
        default: readData = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- eboxSync.sv
// Phase counts gatedEn pulses up to timeField; a larger phase wraps round to reach it
// eboxClk is combinational and held off by MBOX wait and machine reset
`default_nettype none

module eboxSync (
  input  logic                      MAIN_SOURCE,
  input  logic                      CLK,
  funcBus.consumer                  fb,
  input  logic                      gatedEn,
  input  logic                      mrReset,
  input  logic [clkPkg::TIME_W-1:0] timeField,
  input  logic                      mboxWait,
  output logic                      eboxClk,
  output logic                      clkCrm,
  output logic                      clkEdp,
  output logic                      clkCtl,
  output logic [2:0]                eboxDis
);
  import clkPkg::*;

  logic [TIME_W-1:0] phase;
  logic              phaseMatch;

  // Disables from data bits 33-35, crm edp ctl
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      eboxDis <= '0;
    end else if (fb.ldEboxDis) begin
      eboxDis <= fb.loadData[2:0];
    end
  end

  assign phaseMatch = (phase == timeField);
  assign eboxClk    = gatedEn & phaseMatch & ~mboxWait & ~mrReset;

  // Phase sync counter
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      phase <= '0;
    end else if (eboxClk) begin
      phase <= '0;
    end else if (gatedEn && !phaseMatch) begin
      phase <= phase + 1'b1;
    end
    // Otherwise hold at timeField, waiting on MBOX or reset
  end

  // Per-section enables
  assign clkCrm = eboxClk & ~eboxDis[2];
  assign clkEdp = eboxClk & ~eboxDis[1];
  assign clkCtl = eboxClk & ~eboxDis[0];

endmodule

`default_nettype wire

//--- funcBus.sv
// Decoded diagnostic function pulses, each high for one MAIN_SOURCE cycle
// No handshake; loadData is only meaningful in a pulse cycle
`default_nettype none

interface funcBus;
  import clkPkg::*;

  // Control function pulses
  logic start;
  logic singleStep;
  logic burst;
  logic clrReset;
  logic setReset;

  // Load function pulses
  logic ldBurstLsb;
  logic ldBurstMsb;
  logic ldRateSource;
  logic ldEboxDis;

  // Load nibble, valid with a load pulse
  logic [LOAD_W-1:0] loadData;

  modport decoder (
    output start,
    output singleStep,
    output burst,
    output clrReset,
    output setReset,
    output ldBurstLsb,
    output ldBurstMsb,
    output ldRateSource,
    output ldEboxDis,
    output loadData
  );

  modport consumer (
    input start,
    input singleStep,
    input burst,
    input clrReset,
    input setReset,
    input ldBurstLsb,
    input ldBurstMsb,
    input ldRateSource,
    input ldEboxDis,
    input loadData
  );

endinterface

`default_nettype wire

//--- resetControl.sv
// mrReset comes up set; ebusReset stretches EBUS_RESET_CYCLES past reset or SET_RESET
`default_nettype none

module resetControl (
  input  logic      MAIN_SOURCE,
  input  logic      CLK,
  funcBus.consumer  fb,
  output logic      mrReset,
  output logic      ebusReset
);
  import clkPkg::*;

  logic [EBUS_RESET_W-1:0] stretchCnt;

  // Machine reset flip-flop
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      mrReset <= 1'b1;
    end else if (fb.setReset) begin
      mrReset <= 1'b1;
    end else if (fb.clrReset) begin
      mrReset <= 1'b0;
    end
  end

  // Stretch counter, held loaded during reset
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      stretchCnt <= EBUS_RESET_W'(EBUS_RESET_CYCLES);
    end else if (fb.setReset) begin
      stretchCnt <= EBUS_RESET_W'(EBUS_RESET_CYCLES);
    end else if (stretchCnt != '0) begin
      stretchCnt <= stretchCnt - 1'b1;
    end
  end

  // High while any count remains
  assign ebusReset = (stretchCnt != '0);

endmodule

`default_nettype wire

//--- sources.f
clkPkg.sv
funcBus.sv
diagFunctionDecoder.sv
resetControl.sv
burstCounter.sv
clockGate.sv
eboxSync.sv
diagReadback.sv
clockControl.sv
clockControl_properties.sv
clockControl_tb.sv
